//--- source/sram_pkg.sv
package sram_pkg;

  // SRAM geometry
  localparam int addr_w = 16;
  localparam int data_w = 8;
  localparam int strb_w = data_w / 8; // One strobe per byte

  typedef enum logic [0:0] {
    OP_READ  = 1'b0,
    OP_WRITE = 1'b1
  } sram_op_t;

  // Host command, one per handshake
  typedef struct packed {
    logic [addr_w-1:0] addr;
    sram_op_t          op;
    logic [data_w-1:0] wr_data;
    logic [strb_w-1:0] wr_strb;
  } sram_cmd_t;

  // What a path asks of the pins while it is active
  typedef struct packed {
    logic [addr_w-1:0] addr;
    logic [data_w-1:0] data;
    logic              data_oe; // Drive the data bus
    logic              we_n;
    logic              oe_n;
  } pin_drive_t;

  typedef enum logic [1:0] {
    S_IDLE  = 2'd0,
    S_WRITE = 2'd1,
    S_READ  = 2'd2
  } seq_state_t;

endpackage

//--- source/sram_wr_path.sv
module sram_wr_path (
  input  logic                  clk,
  input  logic                  rst_n,
  input  logic                  start,
  input  sram_pkg::sram_cmd_t   cmd,
  output sram_pkg::pin_drive_t  drive,
  output logic                  active
);

  logic [sram_pkg::addr_w-1:0] addr_q;
  logic [sram_pkg::data_w-1:0] data_q;
  logic                        we_n_q;
  logic                        data_oe_q;
  logic                        active_q;
  logic                        strobe_on;

  // Zero strobe still spends the cycle but leaves we_n high
  assign strobe_on = |cmd.wr_strb;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      active_q  <= 1'b0;
      we_n_q    <= 1'b1;
      data_oe_q <= 1'b0;
    end else begin
      active_q  <= start;
      we_n_q    <= ~(start & strobe_on);
      data_oe_q <= start & strobe_on;
    end
  end

  always_ff @(posedge clk) begin
    if (start) begin
      addr_q <= cmd.addr;
      data_q <= cmd.wr_data;
    end
  end

  always_comb begin
    drive         = '0;
    drive.addr    = addr_q;
    drive.data    = data_q;
    drive.data_oe = data_oe_q;
    drive.we_n    = we_n_q;
    drive.oe_n    = 1'b1; // Never reads
  end

  assign active = active_q;

endmodule

//--- source/sram_rd_path.sv
module sram_rd_path (
  input  logic                         clk,
  input  logic                         rst_n,
  input  logic                         start,
  input  logic [sram_pkg::addr_w-1:0]  addr,
  input  logic [sram_pkg::data_w-1:0]  data_in,
  input  logic                         resp_ready,
  output sram_pkg::pin_drive_t         drive,
  output logic                         active,
  output logic                         resp_valid,
  output logic [sram_pkg::data_w-1:0]  resp_data
);

  logic [sram_pkg::addr_w-1:0] addr_q;
  logic [sram_pkg::data_w-1:0] data_q;
  logic                        oe_n_q;
  logic                        active_q;
  logic                        valid_q;
  logic                        capture;
  logic                        taken;

  // Sample at the end of the oe_n low cycle
  assign capture = active_q;
  assign taken   = valid_q & resp_ready;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      active_q <= 1'b0;
      oe_n_q   <= 1'b1;
      valid_q  <= 1'b0;
    end else begin
      active_q <= start;
      oe_n_q   <= ~start;

      if (capture) begin
        valid_q <= 1'b1; // May replace a response taken on this edge
      end else if (taken) begin
        valid_q <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (start) begin
      addr_q <= addr;
    end
    if (capture) begin
      data_q <= data_in;
    end
  end

  always_comb begin
    drive         = '0;
    drive.addr    = addr_q;
    drive.data_oe = 1'b0; // Bus belongs to the SRAM
    drive.we_n    = 1'b1;
    drive.oe_n    = oe_n_q;
  end

  assign active     = active_q;
  assign resp_valid = valid_q;
  assign resp_data  = data_q;

endmodule

//--- source/sram_io_seq.sv
module sram_io_seq (
  input  logic                         clk,
  input  logic                         rst_n,

  input  logic                         cmd_valid,
  input  sram_pkg::sram_cmd_t          cmd,
  output logic                         cmd_ready,

  input  sram_pkg::pin_drive_t         wr_drive,
  input  sram_pkg::pin_drive_t         rd_drive,
  input  logic                         wr_active,
  input  logic                         rd_active,
  input  logic                         resp_valid,
  input  logic                         resp_ready,

  output logic                         wr_start,
  output logic                         rd_start,
  output sram_pkg::sram_cmd_t          cmd_q,
  output logic [sram_pkg::data_w-1:0]  data_in,

  output logic [sram_pkg::addr_w-1:0]  sram_addr,
  inout  wire  [sram_pkg::data_w-1:0]  sram_data,
  output logic                         sram_we_n,
  output logic                         sram_oe_n,
  output logic                         sram_ce_n
);

  sram_pkg::seq_state_t state;
  sram_pkg::seq_state_t state_d;
  sram_pkg::pin_drive_t pins;
  logic                 is_read;
  logic                 resp_held;
  logic                 accept;

  assign is_read   = (cmd.op == sram_pkg::OP_READ);
  assign resp_held = resp_valid & ~resp_ready;

  // Reads wait while a response is stalled, writes do not
  assign cmd_ready = (state == sram_pkg::S_IDLE) && !(is_read && resp_held);
  assign accept    = cmd_valid & cmd_ready;

  // Single cycle pulses, ready drops right after
  assign wr_start = accept & ~is_read;
  assign rd_start = accept & is_read;
  assign cmd_q    = cmd; // Held by the host until the handshake

  always_comb begin
    state_d = state;
    case (state)
      sram_pkg::S_IDLE: begin
        if (accept) begin
          state_d = is_read ? sram_pkg::S_READ : sram_pkg::S_WRITE;
        end
      end
      sram_pkg::S_WRITE: state_d = sram_pkg::S_IDLE;
      sram_pkg::S_READ:  state_d = sram_pkg::S_IDLE;
      default:           state_d = sram_pkg::S_IDLE;
    endcase
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state <= sram_pkg::S_IDLE;
    end else begin
      state <= state_d;
    end
  end

  // Pin merge, idle drive when no path owns the pins
  always_comb begin
    pins      = '0;
    pins.we_n = 1'b1;
    pins.oe_n = 1'b1;
    if (wr_active) begin
      pins = wr_drive;
    end else if (rd_active) begin
      pins = rd_drive;
    end
  end

  assign sram_addr = pins.addr;
  assign sram_we_n = pins.we_n;
  assign sram_oe_n = pins.oe_n;
  assign sram_ce_n = 1'b0; // Chip stays selected

  assign sram_data = pins.data_oe ? pins.data : 'z;
  assign data_in   = sram_data;

endmodule

//--- source/sram_ctrl_top.sv
module sram_ctrl_top (
  input  logic                         clk,
  input  logic                         rst_n,

  input  logic                         cmd_valid,
  output logic                         cmd_ready,
  input  sram_pkg::sram_cmd_t          cmd,

  output logic                         resp_valid,
  input  logic                         resp_ready,
  output logic [sram_pkg::data_w-1:0]  resp_data,

  output logic [sram_pkg::addr_w-1:0]  sram_addr,
  inout  wire  [sram_pkg::data_w-1:0]  sram_data,
  output logic                         sram_we_n,
  output logic                         sram_oe_n,
  output logic                         sram_ce_n
);

  sram_pkg::pin_drive_t        wr_drive;
  sram_pkg::pin_drive_t        rd_drive;
  sram_pkg::sram_cmd_t         cmd_q;
  logic                        wr_active;
  logic                        rd_active;
  logic                        wr_start;
  logic                        rd_start;
  logic [sram_pkg::data_w-1:0] data_in;

  sram_io_seq u_seq (
    .clk        (clk),
    .rst_n      (rst_n),
    .cmd_valid  (cmd_valid),
    .cmd        (cmd),
    .cmd_ready  (cmd_ready),
    .wr_drive   (wr_drive),
    .rd_drive   (rd_drive),
    .wr_active  (wr_active),
    .rd_active  (rd_active),
    .resp_valid (resp_valid),
    .resp_ready (resp_ready),
    .wr_start   (wr_start),
    .rd_start   (rd_start),
    .cmd_q      (cmd_q),
    .data_in    (data_in),
    .sram_addr  (sram_addr),
    .sram_data  (sram_data),
    .sram_we_n  (sram_we_n),
    .sram_oe_n  (sram_oe_n),
    .sram_ce_n  (sram_ce_n)
  );

  sram_wr_path u_wr (
    .clk    (clk),
    .rst_n  (rst_n),
    .start  (wr_start),
    .cmd    (cmd_q),
    .drive  (wr_drive),
    .active (wr_active)
  );

  sram_rd_path u_rd (
    .clk        (clk),
    .rst_n      (rst_n),
    .start      (rd_start),
    .addr       (cmd_q.addr),
    .data_in    (data_in),
    .resp_ready (resp_ready),
    .drive      (rd_drive),
    .active     (rd_active),
    .resp_valid (resp_valid),
    .resp_data  (resp_data)
  );

endmodule

//--- verification/sram_model.sv
module sram_model (
  input  logic [sram_pkg::addr_w-1:0] addr,
  inout  wire  [sram_pkg::data_w-1:0] data,
  input  logic                        we_n,
  input  logic                        oe_n,
  input  logic                        ce_n
);
  timeunit 1ns;
  timeprecision 100ps;

  logic [7:0] mem [0:65535];

  function automatic logic [7:0] fill_byte(input logic [15:0] a);
    return a[7:0] ^ a[15:8] ^ 8'h3c; // Both address bytes count
  endfunction

  initial begin
    for (int i = 0; i < 65536; i++) begin
      mem[i] = fill_byte(16'(i));
    end
  end

  // No access time modelled
  assign data = (!ce_n && !oe_n && we_n) ? mem[addr] : 8'bz;

  // Write lands mid-pulse once the pins have settled
  always @(negedge we_n) begin
    #4;
    if (!we_n && !ce_n) begin
      mem[addr] = data;
    end
  end

endmodule

//--- verification/sram_ctrl_tb.sv
module sram_ctrl_tb;
  timeunit 1ns;
  timeprecision 100ps;

  localparam int wait_limit = 200; // Cycles per wait loop

  logic                        clk = 1'b0;
  logic                        rst_n;
  logic                        cmd_valid;
  logic                        cmd_ready;
  sram_pkg::sram_cmd_t         cmd;
  logic                        resp_valid;
  logic                        resp_ready;
  logic [sram_pkg::data_w-1:0] resp_data;
  logic [sram_pkg::addr_w-1:0] sram_addr;
  wire  [sram_pkg::data_w-1:0] sram_data;
  logic                        sram_we_n;
  logic                        sram_oe_n;
  logic                        sram_ce_n;

  integer              seed = 10448;
  int                  errors = 0;
  int                  tests_run = 0;
  int                  tests_failed = 0;
  int                  cycles;
  logic [7:0]          sb [0:65535]; // Mirror of the SRAM
  logic [7:0]          expect_q [$];
  sram_pkg::sram_cmd_t ops [0:199];

  always #5 clk = ~clk;

  always @(posedge clk) begin
    if (!rst_n) begin
      cycles <= 0;
    end else begin
      cycles <= cycles + 1;
    end
  end

  sram_ctrl_top DUT (
    .clk        (clk),
    .rst_n      (rst_n),
    .cmd_valid  (cmd_valid),
    .cmd_ready  (cmd_ready),
    .cmd        (cmd),
    .resp_valid (resp_valid),
    .resp_ready (resp_ready),
    .resp_data  (resp_data),
    .sram_addr  (sram_addr),
    .sram_data  (sram_data),
    .sram_we_n  (sram_we_n),
    .sram_oe_n  (sram_oe_n),
    .sram_ce_n  (sram_ce_n)
  );

  sram_model u_mem (
    .addr (sram_addr),
    .data (sram_data),
    .we_n (sram_we_n),
    .oe_n (sram_oe_n),
    .ce_n (sram_ce_n)
  );

  // Power-up contents, mixed from both address bytes
  function automatic logic [7:0] power_on_byte(input logic [15:0] a);
    return a[7:0] ^ a[15:8] ^ 8'h3c;
  endfunction

  function automatic sram_pkg::sram_cmd_t make_cmd(input logic [15:0] a,
      input sram_pkg::sram_op_t op, input logic [7:0] d, input logic s);
    sram_pkg::sram_cmd_t c;
    c.addr    = a;
    c.op      = op;
    c.wr_data = d;
    c.wr_strb = s;
    return c;
  endfunction

  task automatic check_value(input string name, input logic [31:0] got,
      input logic [31:0] exp);
    assert (got === exp) else begin
      $display("FAIL %s got 0x%0h expected 0x%0h", name, got, exp);
      errors++;
    end
  endtask

  task automatic next_cycle();
    @(posedge clk);
    #1;
  endtask

  task automatic end_test(input string name, input int mark);
    tests_run++;
    if (errors == mark) begin
      $display("test %0d %s: ok", tests_run, name);
    end else begin
      tests_failed++;
      $display("test %0d %s: %0d errors", tests_run, name, errors - mark);
    end
  endtask

  // Holds the command until accepted, checks its pin cycle, then updates the mirror
  task automatic send_cmd(input sram_pkg::sram_cmd_t c);
    int n;
    bit taken;
    n     = 0;
    taken = 1'b0;
    cmd       = c;
    cmd_valid = 1'b1;
    while (!taken && n < wait_limit) begin
      @(negedge clk);
      if (c.op == sram_pkg::OP_READ && resp_valid && !resp_ready) begin
        check_value("cmd_ready", 32'(cmd_ready), 32'h0); // Read refused while held
      end
      taken = cmd_ready;
      n++;
      next_cycle();
    end
    cmd_valid = 1'b0;
    if (!taken) begin
      $display("Timeout: command to address 0x%0h was never accepted", c.addr);
      errors++;
    end else if (c.op == sram_pkg::OP_WRITE) begin
      if (c.wr_strb != '0) begin
        check_value("sram_we_n", 32'(sram_we_n), 32'h0);
        check_value("sram_addr", 32'(sram_addr), 32'(c.addr));
        check_value("sram_data", 32'(sram_data), 32'(c.wr_data));
        sb[c.addr] = c.wr_data;
      end
    end else begin
      check_value("sram_oe_n", 32'(sram_oe_n), 32'h0);
      check_value("sram_addr", 32'(sram_addr), 32'(c.addr));
      expect_q.push_back(sb[c.addr]);
    end
  endtask

  task automatic drain_resps(input int count, input bit random_ready);
    int got;
    int n;
    bit held;
    logic [7:0] held_data;
    logic [31:0] r;
    got  = 0;
    n    = 0;
    held = 1'b0;
    while (got < count && n < wait_limit) begin
      r = $random(seed);
      resp_ready = random_ready ? r[0] : 1'b1;
      @(negedge clk);
      if (resp_valid && held) begin
        check_value("resp_data held", 32'(resp_data), 32'(held_data));
      end
      held = 1'b0;
      n++;
      if (resp_valid && resp_ready) begin
        if (expect_q.size() == 0) begin
          $display("Response arrived with no read outstanding");
          errors++;
        end else begin
          check_value("resp_data", 32'(resp_data), 32'(expect_q.pop_front()));
        end
        got++;
        n = 0;
      end else if (resp_valid) begin
        held      = 1'b1;
        held_data = resp_data;
      end
      next_cycle();
    end
    resp_ready = 1'b0;
    if (got < count) begin
      $display("Timeout: only %0d of %0d read responses arrived", got, count);
      errors++;
    end
  endtask

  task automatic wait_resp_valid();
    int n;
    n = 0;
    @(negedge clk);
    while (!resp_valid && n < wait_limit) begin
      next_cycle();
      @(negedge clk);
      n++;
    end
    if (!resp_valid) begin
      $display("Timeout: no read response appeared");
      errors++;
    end
  endtask

  initial begin
    int mark;
    int start;
    int n_reads;
    logic [31:0] r;
    logic [7:0] first;
    sram_pkg::sram_cmd_t c;
    rst_n      = 1'b0;
    cmd_valid  = 1'b0;
    cmd        = '0;
    resp_ready = 1'b0;
    for (int i = 0; i < 65536; i++) begin
      sb[i] = power_on_byte(16'(i));
    end
    repeat (8) @(posedge clk);
    #1;
    rst_n = 1'b1;

    mark = errors;
    @(negedge clk);
    check_value("sram_ce_n", 32'(sram_ce_n), 32'h0);
    check_value("sram_oe_n", 32'(sram_oe_n), 32'h1);
    check_value("sram_we_n", 32'(sram_we_n), 32'h1);
    check_value("cmd_ready", 32'(cmd_ready), 32'h1);
    check_value("resp_valid", 32'(resp_valid), 32'h0);
    next_cycle();
    end_test("reset state", mark);

    mark = errors;
    send_cmd(make_cmd(16'h1234, sram_pkg::OP_WRITE, 8'ha5, 1'b1));
    send_cmd(make_cmd(16'h1234, sram_pkg::OP_READ, 8'h00, 1'b0));
    drain_resps(1, 1'b0);
    end_test("write then read", mark);

    mark = errors;
    send_cmd(make_cmd(16'h0456, sram_pkg::OP_WRITE, 8'h5c, 1'b1));
    send_cmd(make_cmd(16'h0456, sram_pkg::OP_WRITE, 8'ha3, 1'b0)); // Must not land
    send_cmd(make_cmd(16'h0456, sram_pkg::OP_READ, 8'h00, 1'b0));
    drain_resps(1, 1'b0);
    end_test("zero strobe write", mark);

    mark  = errors;
    start = cycles;
    for (int i = 0; i < 16; i++) begin
      send_cmd(make_cmd(16'h0800 + 16'(i), sram_pkg::OP_WRITE, 8'(i * 7 + 3), 1'b1));
    end
    next_cycle(); // Last write pin cycle
    assert (cycles - start <= 32) else begin
      $display("FAIL write cycles 0x%0h exceeds 0x20", cycles - start);
      errors++;
    end
    for (int i = 0; i < 16; i++) begin
      send_cmd(make_cmd(16'h0800 + 16'(i), sram_pkg::OP_READ, 8'h00, 1'b0));
      drain_resps(1, 1'b0);
    end
    end_test("back-to-back writes", mark);

    mark = errors;
    send_cmd(make_cmd(16'h0300, sram_pkg::OP_WRITE, 8'h11, 1'b1));
    send_cmd(make_cmd(16'h0301, sram_pkg::OP_WRITE, 8'h22, 1'b1));
    send_cmd(make_cmd(16'h0300, sram_pkg::OP_READ, 8'h00, 1'b0));
    wait_resp_valid();
    first = resp_data;
    next_cycle();
    cmd       = make_cmd(16'h0301, sram_pkg::OP_READ, 8'h00, 1'b0);
    cmd_valid = 1'b1;
    repeat (6) begin
      @(negedge clk);
      check_value("cmd_ready", 32'(cmd_ready), 32'h0);
      check_value("resp_data", 32'(resp_data), 32'(first));
      next_cycle();
    end
    fork
      send_cmd(make_cmd(16'h0301, sram_pkg::OP_READ, 8'h00, 1'b0));
      drain_resps(2, 1'b0);
    join
    end_test("response back-pressure", mark);

    mark    = errors;
    n_reads = 0;
    for (int i = 0; i < 200; i++) begin
      r = $random(seed);
      c = make_cmd({10'h080, r[5:0]}, r[8] ? sram_pkg::OP_WRITE : sram_pkg::OP_READ,
                   r[23:16], r[12]);
      ops[i] = c;
      if (!r[8]) begin
        n_reads++;
      end
    end
    fork
      for (int i = 0; i < 200; i++) begin
        send_cmd(ops[i]);
      end
      drain_resps(n_reads, 1'b1);
    join
    end_test("random traffic", mark);

    $display("tests run %0d, tests failed %0d, check errors %0d",
             tests_run, tests_failed, errors);
    if (errors == 0) begin
      $display("sim passed");
    end else begin
      $display("sim failed");
    end
    $finish;
  end

endmodule

//--- build.f
source/sram_pkg.sv
source/sram_wr_path.sv
source/sram_rd_path.sv
source/sram_io_seq.sv
source/sram_ctrl_top.sv
verification/sram_model.sv
verification/sram_ctrl_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Verilator build and run, verdict taken from the simulation log
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --timing --assert --timescale 1ns/1ps -j 0 \
  --top-module sram_ctrl_tb -f build.f -o sram_sim \
  && ./obj_dir/sram_sim > sim.log 2>&1 \
  || { cat sim.log 2>/dev/null; echo "Build or run error"; exit 1; }
cat sim.log
grep -q "sim failed" sim.log \
  && { echo "Result: FAIL"; exit 1; } \
  || { echo "Result: PASS"; exit 0; }
